//--- hw/lut_pkg.sv
package lut_pkg;

   // Table word and key widths
   localparam int DATA_W     = 32;
   localparam int KEY_W      = 7;
   // One extra bit selects the bank
   localparam int RAM_ADDR_W = KEY_W + 1;
   localparam int BUS_ADDR_W = 32;
   localparam int LEN_W      = 8;
   localparam int CFG_ADDR_W = 3;

   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [KEY_W-1:0]      key_t;
   typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
   typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
   typedef logic [LEN_W-1:0]      len_t;
   typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

   // Register map
   localparam cfg_addr_t REG_EXT_ADDR = 3'd0;
   localparam cfg_addr_t REG_LENGTH   = 3'd1;
   localparam cfg_addr_t REG_COUNT    = 3'd2;
   localparam cfg_addr_t REG_STRIDE   = 3'd3;
   localparam cfg_addr_t REG_PINGPONG = 3'd4;

   // Address generator states
   typedef enum logic [1:0] {
      IDLE,
      GEN,
      FINISH
   } loader_state_t;

endpackage

//--- hw/lut_cfg_regs.sv
`timescale 1ns/1ps

module lut_cfg_regs import lut_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      cfg_valid,
   output logic      cfg_ready,
   input  cfg_addr_t cfg_addr,
   input  data_t     cfg_wdata,
   input  logic      busy,
   output bus_addr_t ext_addr,
   output len_t      length,
   output len_t      count,
   output key_t      stride,
   output logic      ping_pong
);

   logic wr_en;

   // Configuration is frozen while a load runs
   assign cfg_ready = !busy;
   assign wr_en     = cfg_valid && cfg_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ext_addr  <= '0;
         length    <= '0;
         count     <= '0;
         stride    <= '0;
         ping_pong <= 1'b0;
      end else if (wr_en) begin
         case (cfg_addr)
            REG_EXT_ADDR: ext_addr  <= cfg_wdata;
            REG_LENGTH:   length    <= cfg_wdata[LEN_W-1:0];
            REG_COUNT:    count     <= cfg_wdata[LEN_W-1:0];
            REG_STRIDE:   stride    <= cfg_wdata[KEY_W-1:0];
            REG_PINGPONG: ping_pong <= cfg_wdata[0];
            default: ;
         endcase
      end
   end

   // Nothing may change under a running load
   a_no_write_busy: assert property (
      @(posedge clk) disable iff (rst)
      busy |=> $stable({ext_addr, length, count, stride, ping_pong})
   ) else $error("configuration changed while busy");

endmodule

//--- hw/lut_addr_gen.sv
`timescale 1ns/1ps

module lut_addr_gen import lut_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic run,
   input  len_t count,
   input  key_t stride,
   output logic gen_valid,
   input  logic gen_ready,
   output key_t gen_addr
);

   loader_state_t state;
   len_t          remaining;

   assign gen_valid = (state == GEN);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= IDLE;
         gen_addr  <= '0;
         remaining <= '0;
      end else if (run) begin
         // A new run restarts from key zero
         gen_addr  <= '0;
         remaining <= count;
         state     <= (count == '0) ? FINISH : GEN;
      end else begin
         case (state)
            GEN: begin
               if (gen_valid && gen_ready) begin
                  gen_addr  <= gen_addr + stride;
                  remaining <= remaining - 1'b1;
                  if (remaining == len_t'(1))
                     state <= FINISH;
               end
            end
            FINISH:  state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   a_addr_stable: assert property (
      @(posedge clk) disable iff (rst)
      gen_valid && !gen_ready && !run |=> $stable(gen_addr)
   ) else $error("gen_addr changed while stalled");

endmodule

//--- hw/lut_mem_writer.sv
`timescale 1ns/1ps

module lut_mem_writer import lut_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  gen_valid,
   output logic  gen_ready,
   input  key_t  gen_addr,
   input  logic  bus_ready,
   input  data_t bus_rdata,
   output logic  bus_valid,
   input  logic  stop,
   output logic  mem_we,
   output key_t  mem_addr,
   output data_t mem_data
);

   logic beat;

   // Keep requesting until the burst ends so excess beats drain
   assign bus_valid = !stop;
   assign beat      = bus_valid && bus_ready;
   // An address is only taken together with a beat
   assign gen_ready = beat;

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         mem_we <= 1'b0;
      else
         mem_we <= beat && gen_valid;
   end

   always_ff @(posedge clk) begin
      mem_addr <= gen_addr;
      mem_data <= bus_rdata;
   end

endmodule

//--- hw/lut_dp_ram.sv
`timescale 1ns/1ps

module lut_dp_ram import lut_pkg::*; (
   input  logic      clk,
   input  ram_addr_t a_addr,
   output data_t     a_rdata,
   input  logic      b_we,
   input  ram_addr_t b_addr,
   input  data_t     b_wdata
);

   // Both banks, bank bit on top
   data_t mem [2**RAM_ADDR_W];

   // Lookup side
   always_ff @(posedge clk) begin
      a_rdata <= mem[a_addr];
   end

   // Loader side
   always_ff @(posedge clk) begin
      if (b_we)
         mem[b_addr] <= b_wdata;
   end

endmodule

//--- hw/lut_read_unit.sv
`timescale 1ns/1ps

module lut_read_unit import lut_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   output logic      done,
   input  bus_addr_t ext_addr,
   input  len_t      length,
   input  len_t      count,
   input  key_t      stride,
   input  logic      ping_pong,
   output logic      bus_valid,
   output bus_addr_t bus_addr,
   output len_t      bus_len,
   input  logic      bus_ready,
   input  data_t     bus_rdata,
   input  logic      bus_last,
   input  logic      key_valid,
   input  key_t      key,
   output logic      value_valid,
   output ram_addr_t ram_a_addr,
   output logic      ram_b_we,
   output ram_addr_t ram_b_addr,
   output data_t     ram_b_wdata
);

   logic active_bank;
   logic key_valid_d;
   logic gen_valid;
   logic gen_ready;
   key_t gen_addr;
   key_t wr_key;

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         done <= 1'b1;
      else if (run)
         done <= 1'b0;
      else if (bus_valid && bus_ready && bus_last)
         done <= 1'b1;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         active_bank <= 1'b0;
      else if (run)
         active_bank <= ping_pong ? !active_bank : 1'b0;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bus_addr <= '0;
         bus_len  <= '0;
      end else if (run) begin
         bus_addr <= ext_addr;
         bus_len  <= length;
      end
   end

   // Two-stage lookup, address register then RAM read
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         key_valid_d <= 1'b0;
         value_valid <= 1'b0;
      end else begin
         key_valid_d <= key_valid;
         value_valid <= key_valid_d;
      end
   end

   always_ff @(posedge clk) begin
      ram_a_addr <= {active_bank, key};
   end

   lut_addr_gen addr_gen_i (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .count     (count),
      .stride    (stride),
      .gen_valid (gen_valid),
      .gen_ready (gen_ready),
      .gen_addr  (gen_addr)
   );

   lut_mem_writer mem_writer_i (
      .clk       (clk),
      .rst       (rst),
      .gen_valid (gen_valid),
      .gen_ready (gen_ready),
      .gen_addr  (gen_addr),
      .bus_ready (bus_ready),
      .bus_rdata (bus_rdata),
      .bus_valid (bus_valid),
      .stop      (done),
      .mem_we    (ram_b_we),
      .mem_addr  (wr_key),
      .mem_data  (ram_b_wdata)
   );

   // Loads always land in the bank not being looked up
   assign ram_b_addr = {!active_bank, wr_key};

   a_run_when_done: assert property (
      @(posedge clk) disable iff (rst)
      run |-> done
   ) else $error("run issued while a load is in progress");

endmodule

//--- hw/lut_top.sv
`timescale 1ns/1ps

module lut_top import lut_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      cfg_valid,
   output logic      cfg_ready,
   input  cfg_addr_t cfg_addr,
   input  data_t     cfg_wdata,
   input  logic      run,
   output logic      done,
   output logic      bus_valid,
   output bus_addr_t bus_addr,
   output len_t      bus_len,
   input  logic      bus_ready,
   input  data_t     bus_rdata,
   input  logic      bus_last,
   input  logic      key_valid,
   input  key_t      key,
   output logic      value_valid,
   output data_t     value
);

   bus_addr_t ext_addr;
   len_t      length;
   len_t      count;
   key_t      stride;
   logic      ping_pong;
   ram_addr_t ram_a_addr;
   logic      ram_b_we;
   ram_addr_t ram_b_addr;
   data_t     ram_b_wdata;

   lut_cfg_regs cfg_regs_i (
      .clk       (clk),
      .rst       (rst),
      .cfg_valid (cfg_valid),
      .cfg_ready (cfg_ready),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .busy      (!done),
      .ext_addr  (ext_addr),
      .length    (length),
      .count     (count),
      .stride    (stride),
      .ping_pong (ping_pong)
   );

   lut_read_unit read_unit_i (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .done        (done),
      .ext_addr    (ext_addr),
      .length      (length),
      .count       (count),
      .stride      (stride),
      .ping_pong   (ping_pong),
      .bus_valid   (bus_valid),
      .bus_addr    (bus_addr),
      .bus_len     (bus_len),
      .bus_ready   (bus_ready),
      .bus_rdata   (bus_rdata),
      .bus_last    (bus_last),
      .key_valid   (key_valid),
      .key         (key),
      .value_valid (value_valid),
      .ram_a_addr  (ram_a_addr),
      .ram_b_we    (ram_b_we),
      .ram_b_addr  (ram_b_addr),
      .ram_b_wdata (ram_b_wdata)
   );

   // Read data goes straight out as the lookup value
   lut_dp_ram dp_ram_i (
      .clk     (clk),
      .a_addr  (ram_a_addr),
      .a_rdata (value),
      .b_we    (ram_b_we),
      .b_addr  (ram_b_addr),
      .b_wdata (ram_b_wdata)
   );

endmodule

//--- verif/lut_tb_clk.sv
`timescale 1ns/1ps

module lut_tb_clk (
   output logic clk
);

   // 100 ns period
   localparam int HALF_PERIOD = 50;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = !clk;
   end

endmodule

//--- verif/lut_tb.sv
`timescale 1ns/1ps

module lut_tb import lut_pkg::*; ();

   localparam int LIMIT = 2000;

   logic      clk;
   logic      rst;
   logic      cfg_valid;
   logic      cfg_ready;
   cfg_addr_t cfg_addr;
   data_t     cfg_wdata;
   logic      run;
   logic      done;
   logic      bus_valid;
   bus_addr_t bus_addr;
   len_t      bus_len;
   logic      bus_ready;
   data_t     bus_rdata;
   logic      bus_last;
   logic      key_valid;
   key_t      key;
   logic      value_valid;
   data_t     value;

   // External memory, reference table and bus model state
   data_t     ext_mem [256];
   data_t     model_mem [256];
   bit        model_ok [256];
   logic      model_bank;
   integer    seed;
   int        err_count;
   bus_addr_t mem_base;
   len_t      mem_len;
   logic      gaps_on;
   int        beat_idx;
   int        beat_cnt;
   logic      pv0;
   logic      pv1;
   data_t     pd0;
   data_t     pd1;

   lut_tb_clk clk_gen_i (.clk(clk));

   lut_top lut_top_i (
      .clk         (clk),
      .rst         (rst),
      .cfg_valid   (cfg_valid),
      .cfg_ready   (cfg_ready),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .run         (run),
      .done        (done),
      .bus_valid   (bus_valid),
      .bus_addr    (bus_addr),
      .bus_len     (bus_len),
      .bus_ready   (bus_ready),
      .bus_rdata   (bus_rdata),
      .bus_last    (bus_last),
      .key_valid   (key_valid),
      .key         (key),
      .value_valid (value_valid),
      .value       (value)
   );

   task automatic abort_run;
      $display("Test failures found");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp) begin
         err_count++;
         $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
         abort_run;
      end
   endtask

   task automatic timed_out(input string what);
      err_count++;
      $display("Timeout after %0d cycles waiting for %s", LIMIT, what);
      abort_run;
   endtask

   task automatic next_cycle;
      @(posedge clk);
      #1;
   endtask

   // Bus memory: one beat per valid and ready cycle, optional ready gaps
   initial begin
      logic xfer;
      logic idle;
      bus_ready = 1'b0;
      bus_rdata = '0;
      bus_last  = 1'b0;
      forever begin
         @(negedge clk);
         xfer = bus_valid && bus_ready;
         idle = done;
         next_cycle;
         if (idle)
            beat_idx = 0;
         else if (xfer) begin
            beat_idx++;
            beat_cnt++;
         end
         bus_ready = gaps_on ? (($random(seed) & 3) != 0) : 1'b1;
         bus_rdata = ext_mem[8'(mem_base + beat_idx)];
         bus_last  = (beat_idx == int'(mem_len));
      end
   end

   // Lookup monitor, value due two cycles after the key
   always @(negedge clk) begin
      check("value_valid", value_valid, pv1);
      if (pv1)
         check("value", value, pd1);
      pv1 = pv0;
      pd1 = pd0;
      pv0 = key_valid;
      pd0 = model_mem[{model_bank, key}];
   end

   task automatic write_reg(input cfg_addr_t addr, input data_t data);
      int n;
      cfg_valid = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      for (n = 0; n < LIMIT; n++) begin
         @(negedge clk);
         if (cfg_ready)
            break;
      end
      if (n == LIMIT)
         timed_out("cfg_ready");
      next_cycle;
      cfg_valid = 1'b0;
   endtask

   // Configure, predict the stored words, then pulse run
   task automatic load_table(input bus_addr_t base, input len_t len, input len_t cnt,
                             input key_t stride, input logic pp, input logic gaps);
      int   i;
      key_t k;
      write_reg(REG_EXT_ADDR, base);
      write_reg(REG_LENGTH, 32'(len));
      write_reg(REG_COUNT, 32'(cnt));
      write_reg(REG_STRIDE, 32'(stride));
      write_reg(REG_PINGPONG, 32'(pp));
      model_bank = pp ? !model_bank : 1'b0;
      for (i = 0; i < int'(cnt) && i <= int'(len); i++) begin
         // Keys wrap modulo 128
         k = key_t'(i * int'(stride));
         model_mem[{!model_bank, k}] = ext_mem[8'(base + i)];
         model_ok[{!model_bank, k}]  = 1'b1;
      end
      mem_base = base;
      mem_len  = len;
      gaps_on  = gaps;
      beat_cnt = 0;
      run = 1'b1;
      next_cycle;
      run = 1'b0;
      check("done after run", done, 1'b0);
   endtask

   task automatic wait_done(input bus_addr_t base, input len_t len);
      int   n;
      logic prev_last;
      prev_last = 1'b0;
      for (n = 0; n < LIMIT; n++) begin
         @(negedge clk);
         // done rises exactly one cycle after the last beat
         check("done", done, prev_last);
         if (done)
            break;
         check("bus_valid", bus_valid, 1'b1);
         check("bus_addr", bus_addr, base);
         check("bus_len", bus_len, len);
         prev_last = bus_ready && bus_last;
      end
      if (n == LIMIT)
         timed_out("done");
      check("bus_valid", bus_valid, 1'b0);
      next_cycle;
   endtask

   // Back-to-back lookups of every key held in the active bank
   task automatic lookup_active;
      int n;
      int k;
      n = 0;
      for (k = 0; k < 128; k++) begin
         if (model_ok[{model_bank, key_t'(k)}]) begin
            key_valid = 1'b1;
            key       = key_t'(k);
            next_cycle;
            n++;
         end
      end
      key_valid = 1'b0;
      repeat (3) next_cycle;
      if (n == 0) begin
         err_count++;
         $display("No loaded entries in the active bank to look up");
         abort_run;
      end
   endtask

   task automatic refuse_while_busy;
      int n;
      cfg_valid = 1'b1;
      cfg_addr  = REG_STRIDE;
      cfg_wdata = 32'd7;
      for (n = 0; n < LIMIT; n++) begin
         @(negedge clk);
         if (done)
            break;
         check("cfg_ready", cfg_ready, 1'b0);
      end
      if (n == LIMIT)
         timed_out("done with a pending register write");
      next_cycle;
      cfg_valid = 1'b0;
   endtask

   task automatic test_reset;
      check("done", done, 1'b1);
      check("bus_valid", bus_valid, 1'b0);
      check("value_valid", value_valid, 1'b0);
   endtask

   task automatic test_pingpong_load;
      load_table(32'h10, 8'd15, 8'd16, 7'd1, 1'b1, 1'b0);
      wait_done(32'h10, 8'd15);
      check("beat count", beat_cnt, 16);
   endtask

   task automatic test_stride_wrap;
      load_table(32'h40, 8'd23, 8'd20, 7'd9, 1'b1, 1'b0);
      // Previous table became active at this run
      fork
         wait_done(32'h40, 8'd23);
         lookup_active;
      join
      check("beat count", beat_cnt, 24);
   endtask

   task automatic test_lookup_during_load;
      load_table(32'h60, 8'd31, 8'd32, 7'd3, 1'b1, 1'b1);
      fork
         wait_done(32'h60, 8'd31);
         lookup_active;
      join
      check("beat count", beat_cnt, 32);
      load_table(32'h90, 8'd7, 8'd8, 7'd5, 1'b1, 1'b0);
      fork
         wait_done(32'h90, 8'd7);
         lookup_active;
      join
      check("beat count", beat_cnt, 8);
   endtask

   task automatic test_pingpong_off;
      // Bank 1 goes to the front first so the return to bank 0 shows
      load_table(32'ha0, 8'd7, 8'd8, 7'd4, 1'b1, 1'b0);
      wait_done(32'ha0, 8'd7);
      check("beat count", beat_cnt, 8);
      load_table(32'hc0, 8'd15, 8'd16, 7'd2, 1'b0, 1'b0);
      fork
         wait_done(32'hc0, 8'd15);
         refuse_while_busy;
      join
      check("beat count", beat_cnt, 16);
      lookup_active;
   endtask

   initial begin
      int i;
      seed       = 73;
      err_count  = 0;
      rst        = 1'b1;
      run        = 1'b0;
      cfg_valid  = 1'b0;
      cfg_addr   = '0;
      cfg_wdata  = '0;
      key_valid  = 1'b0;
      key        = '0;
      model_bank = 1'b0;
      mem_base   = '0;
      mem_len    = '0;
      gaps_on    = 1'b0;
      beat_idx   = 0;
      beat_cnt   = 0;
      pv0        = 1'b0;
      pv1        = 1'b0;
      pd0        = '0;
      pd1        = '0;
      for (i = 0; i < 256; i++) begin
         ext_mem[i]  = $random(seed);
         model_ok[i] = 1'b0;
      end
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      next_cycle;
      test_reset;
      test_pingpong_load;
      test_stride_wrap;
      test_lookup_during_load;
      test_pingpong_off;
      if (err_count == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         $display("Test failures found");
         $fatal(1, "errors were recorded");
      end
   end

endmodule

//--- project.f
hw/lut_pkg.sv
hw/lut_cfg_regs.sv
hw/lut_addr_gen.sv
hw/lut_mem_writer.sv
hw/lut_dp_ram.sv
hw/lut_read_unit.sv
hw/lut_top.sv
verif/lut_tb_clk.sv
verif/lut_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lut_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
